/* loader_cases.txt */
# Commands: test <name> | start <index> | end | keep <0|1>
#   wr <addr> <count> <data>... halfwords to consecutive even byte addresses
#   cart <loaded> <type> <flash> <sram> <remap> <max_pak_addr>, all numbers in hex
test reset
cart 0 0 0 0 0 0
test bios_pack
start 00
wr 0008 2 1234 5678
keep 1
wr 0010 2 aaaa 5555
keep 0
wr 0ffc 2 beef dead
end
test cheat_pack
start ff
wr 0000 8 1111 2222 3333 4444 5555 6666 7777 8888
wr 0010 8 a001 b002 c003 d004 e005 f006 0a07 0b08
end
test flash_even
start 81
wr 0100 5 4c46 5341 3148 5f4d 0056
end
cart 1 2 1 0 0 42
test flash_odd
start 81
wr 0200 5 4600 414c 4853 4d31 565f
end
cart 1 2 1 0 0 82
test quirk_sram
start 41
wr 00a0 7 4f52 4b43 2059 4f42 4958 474e 0000
end
cart 1 1 0 1 0 2b
test quirk_both
start c2
wr 00a0 7 455a 444c 2041 0031 0000 0000 0000
end
cart 1 3 0 1 1 2b
test quirk_none
start 81
wr 00a0 7 455a 444c 2041 0032 0000 0000 0000
end
cart 1 2 0 0 0 2b

/* all.f */
+incdir+.
loader_pkg.sv
download_decoder.sv
halfword_packer.sv
flash_tag_detect.sv
quirk_detect.sv
cart_info_regs.sv
rom_loader_top.sv
tb_rom_loader.sv

/* Makefile */
TOP       ?= tb_rom_loader
SEED      ?= 33
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FLIST     ?= all.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP=$(TOP) SEED=$(SEED) LOG=$(LOG)"

test:
	$(VERILATOR) --binary --timing --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_rom_loader.sv */
`timescale 1ns/10ps
`include "loader_config.svh"

module tb_rom_loader
	import loader_pkg::*;
#(
	parameter int SEED = 33
);

	localparam int CLK_PERIOD  = 8;
	localparam int CASE_CYCLES = 64;  // Budget per line of the cases file
	localparam int MARGIN      = 500; // Reset and drain

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        dl_active;
	logic [7:0]  dl_index;
	ioctl_word_t ioctl;
	logic        bios_keep;
	logic        cart_download;
	logic        bios_wr;
	bios_word_t  bios_word;
	logic        cheat_valid;
	cheat_code_t cheat_code;
	logic        cheat_clear;
	cart_info_t  cart_info;

	bios_word_t  bios_q[$];   // Expected BIOS words, oldest first
	cheat_code_t cheat_q[$];  // Expected cheat records
	bios_data_t  bios_model;
	cheat_code_t cheat_model;
	int          clears_exp;
	int          clears_seen;
	int          errors;
	int          test_errors; // Error count when the test began
	int          tests_run;
	int          tests_failed;
	int          case_lines;
	string       test_name;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	rom_loader_top UUT (.*);

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0d ns: %s", $time, msg);
	endtask

	task automatic report_mismatch(input string what, input string got, input string want);
		errors++;
		$display("Mismatch at %0d ns: %s got %s, expected %s", $time, what, got, want);
	endtask

	function automatic string cart_text(input cart_info_t c);
		return $sformatf("loaded %b type %0d flash %b sram %b remap %b max %h", c.cart_loaded,
			c.cart_type, c.flash_1m, c.sram_quirk, c.memory_remap_quirk, c.max_pak_addr);
	endfunction

	task automatic check_bios(input bios_word_t got, input bios_word_t want);
		if (got !== want) begin
			report_mismatch("bios_word", $sformatf("%h", got), $sformatf("%h", want));
		end
	endtask

	task automatic check_cheat(input cheat_code_t got, input cheat_code_t want);
		if (got !== want) begin
			report_mismatch("cheat_code", $sformatf("%h", got), $sformatf("%h", want));
		end
	endtask

	task automatic check_cart(input cart_info_t got, input cart_info_t want);
		if (got !== want) begin
			report_mismatch("cart_info", cart_text(got), cart_text(want));
		end
	endtask

	task automatic check_download(input logic got, input logic want);
		if (got !== want) begin
			report_mismatch("cart_download", $sformatf("%b", got), $sformatf("%b", want));
		end
	endtask

	// Outputs are registered, steady at the falling edge
	always @(negedge clk_sys) begin
		if (!reset) begin
			if (bios_wr && bios_q.size() == 0) report_error("bios_wr pulsed with no word pending");
			else if (bios_wr) check_bios(bios_word, bios_q.pop_front());
			if (cheat_valid && cheat_q.size() == 0) report_error("cheat_valid pulsed unexpectedly");
			else if (cheat_valid) check_cheat(cheat_code, cheat_q.pop_front());
			if (cheat_clear) clears_seen++;
		end
	end

	// ==================================================
	// Stimulus and reference model
	// ==================================================

	task automatic idle(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic start_download(input logic [7:0] index);
		@(negedge clk_sys);
		if (!dl_active && index == 8'(`LDR_CHEAT_INDEX)) clears_exp++; // New cheat file
		dl_index  = index;
		dl_active = 1'b1;
		idle(4); // Class level, then cart_start
		// Anything but the BIOS and cheat slots is a cartridge
		check_download(cart_download, index != 8'd0 && index != 8'(`LDR_CHEAT_INDEX));
	endtask

	task automatic write_half(input logic [`LDR_ADDR_W-1:0] addr, input logic [15:0] data);
		int         slot;
		bios_word_t want;
		@(negedge clk_sys);
		ioctl.wr   = 1'b1;
		ioctl.addr = addr;
		ioctl.dout = data;
		slot       = int'(addr[3:1]);
		if (dl_active && dl_index == 8'd0 && !bios_keep) begin
			if (addr[1]) begin // Upper halfword completes the word
				bios_model[31:16] = data;
				want.addr = addr[`LDR_BIOS_ADDR_W+1:2];
				want.data = bios_model;
				bios_q.push_back(want);
			end else begin
				bios_model[15:0] = data;
			end
		end
		if (dl_active && dl_index == 8'(`LDR_CHEAT_INDEX)) begin
			cheat_model[slot*16 +: 16] = data; // Flags word at the bottom
			if (slot == 7) cheat_q.push_back(cheat_model);
		end
		@(negedge clk_sys);
		ioctl.wr = 1'b0; // Address held for the end latch
		idle($urandom_range(3, 0));
	endtask

	task automatic close_test();
		idle(3); // Let the last pulses drain
		if (bios_q.size() != 0 || cheat_q.size() != 0) begin
			report_error($sformatf("%0d BIOS and %0d cheat words never appeared",
				bios_q.size(), cheat_q.size()));
		end
		if (clears_seen != clears_exp) begin
			report_error($sformatf("cheat_clear pulsed %0d times instead of %0d",
				clears_seen, clears_exp));
		end
		bios_q.delete();
		cheat_q.delete();
		tests_run++;
		if (errors == test_errors) begin
			$display("[%0d ns] %-12s ok", $time, test_name);
		end else begin
			tests_failed++;
			$display("[%0d ns] %-12s failed, %0d error(s)", $time, test_name, errors - test_errors);
		end
	endtask

	// ==================================================
	// Cases file interpreter
	// ==================================================

	initial begin
		int         fd;
		int         rc;
		int         v[6];
		string      op;
		string      line;
		cart_info_t want;

		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = 8'd0;
		ioctl     = '0;
		bios_keep = 1'b0;
		void'($urandom(SEED));

		fd = $fopen("loader_cases.txt", "r"); // First pass counts lines for the watchdog
		while (fd != 0 && $fgets(line, fd) != 0) case_lines++;
		if (fd != 0) $fclose(fd);
		idle(8);
		reset = 1'b0;

		fd = $fopen("loader_cases.txt", "r");
		if (fd == 0) report_error("cannot open loader_cases.txt");
		while (fd != 0 && $fscanf(fd, "%s", op) == 1) begin
			if (op.substr(0, 0) == "#") begin
				rc = $fgets(line, fd); // Rest of a comment line
			end else if (op == "test") begin
				if (test_name != "") close_test();
				rc          = $fscanf(fd, "%s", test_name);
				test_errors = errors;
				clears_exp  = 0;
				clears_seen = 0;
			end else if (op == "start") begin
				rc = $fscanf(fd, "%h", v[0]);
				start_download(v[0][7:0]);
			end else if (op == "end") begin
				@(negedge clk_sys);
				dl_active = 1'b0;
				idle(4); // cart_end, then max_pak_addr
				check_download(cart_download, 1'b0);
			end else if (op == "keep") begin
				rc = $fscanf(fd, "%h", v[0]);
				@(negedge clk_sys);
				bios_keep = v[0][0];
			end else if (op == "wr") begin
				rc = $fscanf(fd, "%h %h", v[0], v[1]); // Start address, halfword count
				for (int i = 0; i < v[1]; i++) begin
					rc = $fscanf(fd, "%h", v[2]);
					write_half(`LDR_ADDR_W'(v[0] + 2 * i), v[2][15:0]);
				end
			end else if (op == "cart") begin
				rc = $fscanf(fd, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
				want = '{cart_loaded: v[0][0], cart_type: v[1][1:0], flash_1m: v[2][0],
					sram_quirk: v[3][0], memory_remap_quirk: v[4][0],
					max_pak_addr: v[5][`LDR_ADDR_W-3:0]};
				check_cart(cart_info, want);
			end else begin
				report_error($sformatf("unknown command '%s' in loader_cases.txt", op));
			end
		end
		if (test_name != "") close_test();
		if (fd != 0) $fclose(fd);

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_run > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog, sized once the cases file is counted
	initial begin
		wait (case_lines > 0);
		#(CLK_PERIOD * (case_lines * CASE_CYCLES + MARGIN));
		$display("Error: watchdog expired, the run hung after %0d ns", $time);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* rom_loader_top.sv */
`timescale 1ns/10ps
`include "loader_config.svh"

module rom_loader_top
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_active,     // Host download level
	input  logic [7:0]  dl_index,
	input  ioctl_word_t ioctl,
	input  logic        bios_keep,     // Keep the current BIOS
	output logic        cart_download,
	output logic        bios_wr,
	output bios_word_t  bios_word,
	output logic        cheat_valid,
	output cheat_code_t cheat_code,
	output logic        cheat_clear,
	output cart_info_t  cart_info
);

	logic                        bios_download;
	logic                        code_download;
	logic                        cart_start;
	logic                        cart_end;
	logic                        bios_en;
	bios_data_t                  bios_data;
	logic [`LDR_BIOS_ADDR_W-1:0] bios_addr;
	logic                        tag_hit;
	logic                        sram_hit;
	logic                        remap_hit;

	// ==================================================
	// Download classes
	// ==================================================

	download_decoder decoder (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_active     (dl_active),
		.dl_index      (dl_index),
		.cart_download (cart_download),
		.bios_download (bios_download),
		.code_download (code_download),
		.cart_start    (cart_start),
		.cart_end      (cart_end),
		.cheat_clear   (cheat_clear)
	);

	// ==================================================
	// Packers
	// ==================================================

	assign bios_en   = bios_download & ~bios_keep; // Keep blocks all BIOS writes
	assign bios_word = '{addr: bios_addr, data: bios_data};

	halfword_packer #(.payload_t(bios_data_t)) bios_packer (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.enable    (bios_en),
		.ioctl     (ioctl),
		.payload   (bios_data),
		.slot_addr (bios_addr),
		.done      (bios_wr)
	);

	halfword_packer #(.payload_t(cheat_code_t)) cheat_packer (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.enable    (code_download),
		.ioctl     (ioctl),
		.payload   (cheat_code),
		.slot_addr (),            // Cheat records carry no word address
		.done      (cheat_valid)
	);

	// ==================================================
	// Cartridge scanners and facts
	// ==================================================

	flash_tag_detect flash_scan (
		.clk_sys (clk_sys),
		.reset   (reset),
		.enable  (cart_download),
		.ioctl   (ioctl),
		.tag_hit (tag_hit)
	);

	quirk_detect quirk_scan (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.enable    (cart_download),
		.ioctl     (ioctl),
		.sram_hit  (sram_hit),
		.remap_hit (remap_hit)
	);

	cart_info_regs cart_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cart_start (cart_start),
		.cart_end   (cart_end),
		.cart_type  (dl_index[7:6]),
		.end_addr   (ioctl.addr),    // Host holds the last address after the download
		.tag_hit    (tag_hit),
		.sram_hit   (sram_hit),
		.remap_hit  (remap_hit),
		.info       (cart_info)
	);

endmodule

/* cart_info_regs.sv */
`timescale 1ns/10ps
`include "loader_config.svh"

module cart_info_regs
	import loader_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_start, // Cartridge download began
	input  logic                   cart_end,   // Cartridge download finished
	input  logic [1:0]             cart_type,  // Index bits 7:6
	input  logic [`LDR_ADDR_W-1:0] end_addr,   // Byte address of the last write
	input  logic                   tag_hit,
	input  logic                   sram_hit,
	input  logic                   remap_hit,
	output cart_info_t             info
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			info <= '0;
		end else begin
			// New image, forget what the scanners found last time
			if (cart_start) begin
				info.cart_loaded        <= 1'b1;
				info.cart_type          <= cart_type;
				info.flash_1m           <= 1'b0;
				info.sram_quirk         <= 1'b0;
				info.memory_remap_quirk <= 1'b0;
			end

			// Scanner pulses are sticky until the next start
			if (tag_hit)   info.flash_1m           <= 1'b1;
			if (sram_hit)  info.sram_quirk         <= 1'b1;
			if (remap_hit) info.memory_remap_quirk <= 1'b1;

			if (cart_end) begin
				info.max_pak_addr <= end_addr[`LDR_ADDR_W-1:2]; // Word address
			end
		end
	end

endmodule

/* quirk_detect.sv */
`timescale 1ns/10ps
`include "loader_config.svh"

module quirk_detect
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        enable,    // Cartridge download level
	input  ioctl_word_t ioctl,
	output logic        sram_hit,  // Pulse, title needs the SRAM quirk
	output logic        remap_hit  // Pulse, title needs the remap quirk
);

	localparam int TITLE_W = `LDR_TITLE_LEN * 8;

	logic [`LDR_ADDR_W-1:0] title_rel; // Byte offset into the title field
	logic [3:0]             title_ofs;
	logic [6:0]             bit_pos;   // Lowest bit of the halfword slot
	logic [TITLE_W-1:0]     title_q;
	logic                   in_title;
	logic                   at_end;    // First write past the title
	logic                   wr_en;
	logic                   sram_match;
	logic                   remap_match;

	assign wr_en     = enable & ioctl.wr;
	assign title_rel = ioctl.addr - `LDR_ADDR_W'(`LDR_TITLE_OFS); // Wraps high below the field
	assign title_ofs = title_rel[3:0];
	assign in_title  = (title_rel < `LDR_ADDR_W'(`LDR_TITLE_LEN));
	assign at_end    = (title_rel == `LDR_ADDR_W'(`LDR_TITLE_LEN));

	// First character lands in the top byte
	assign bit_pos = {4'(`LDR_TITLE_LEN - 2) - title_ofs, 3'd0};

	// ==================================================
	// Title capture
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (wr_en && in_title) begin
			title_q[bit_pos +: 16] <= {ioctl.dout[7:0], ioctl.dout[15:8]}; // Byte swap
		end
	end

	// ==================================================
	// Table compare
	// ==================================================

	always_comb begin
		sram_match  = 1'b0;
		remap_match = 1'b0;
		for (int i = 0; i < `LDR_QUIRK_N; i++) begin
			if (QUIRK_TABLE[i].title == title_q) begin
				sram_match  = sram_match | QUIRK_TABLE[i].sram;
				remap_match = remap_match | QUIRK_TABLE[i].remap;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sram_hit  <= 1'b0;
			remap_hit <= 1'b0;
		end else begin
			sram_hit  <= 1'b0;
			remap_hit <= 1'b0;
			if (wr_en && at_end) begin // Title complete by now
				sram_hit  <= sram_match;
				remap_hit <= remap_match;
			end
		end
	end

endmodule

/* flash_tag_detect.sv */
`timescale 1ns/10ps
`include "loader_config.svh"

module flash_tag_detect
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        enable,  // Cartridge download level
	input  ioctl_word_t ioctl,
	output logic        tag_hit  // Tag seen in the last write
);

	localparam int HIST_W = (`LDR_TAG_BYTES - 1) * 8;

	logic [HIST_W-1:0] history; // Last eight bytes, newest at the bottom
	logic [7:0]        lo_byte;
	logic [7:0]        hi_byte;
	logic              hit_even; // Tag starts at an even address
	logic              hit_odd;  // Tag starts at an odd address
	logic              wr_en;

	assign wr_en   = enable & ioctl.wr;
	assign lo_byte = ioctl.dout[7:0];
	assign hi_byte = ioctl.dout[15:8];

	// Tag ends on this write's low byte
	assign hit_even = ({history, lo_byte} == FLASH_TAG);
	// Drop the oldest byte, tag ends on the high byte
	assign hit_odd  = ({history[HIST_W-9:0], lo_byte, hi_byte} == FLASH_TAG);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			history <= '0;
			tag_hit <= 1'b0;
		end else begin
			tag_hit <= wr_en & (hit_even | hit_odd);
			if (wr_en) begin
				history <= {history[HIST_W-17:0], lo_byte, hi_byte}; // Low byte first
			end
		end
	end

endmodule

/* halfword_packer.sv */
`timescale 1ns/10ps
`include "loader_config.svh"

module halfword_packer
	import loader_pkg::*;
#(
	parameter type payload_t = bios_data_t
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        enable,    // Class level for this payload
	input  ioctl_word_t                 ioctl,
	output payload_t                    payload,
	output logic [`LDR_BIOS_ADDR_W-1:0] slot_addr, // Address bits above the slots
	output logic                        done       // Last slot just written
);

	localparam int PAYLOAD_W = $bits(payload_t);
	localparam int SLOTS     = PAYLOAD_W / `LDR_DATA_W;
	localparam int SLOT_W    = $clog2(SLOTS);

	logic [PAYLOAD_W-1:0] data_q;
	logic [SLOT_W-1:0]    slot;
	logic                 last;
	logic                 wr_en;

	assign wr_en = enable & ioctl.wr;
	assign slot  = ioctl.addr[SLOT_W:1];             // Bit 0 is the byte lane
	assign last  = (slot == SLOT_W'(SLOTS - 1));

	// Payload storage
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			data_q[slot*`LDR_DATA_W +: `LDR_DATA_W] <= ioctl.dout;
		end
		if (wr_en && last) begin
			slot_addr <= ioctl.addr[SLOT_W+1 +: `LDR_BIOS_ADDR_W]; // Word address
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= wr_en & last; // One pulse per completed word
		end
	end

	assign payload = payload_t'(data_q);

endmodule

/* download_decoder.sv */
`timescale 1ns/10ps
`include "loader_config.svh"

module download_decoder (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active,     // Host download level
	input  logic [7:0] dl_index,      // Menu slot of the file being sent
	output logic       cart_download,
	output logic       bios_download,
	output logic       code_download, // Cheat file
	output logic       cart_start,
	output logic       cart_end,
	output logic       cheat_clear    // New cheat file, drop old codes
);

	logic is_bios;
	logic is_cheat;
	logic cart_q;   // Cart level delayed for edge detect
	logic active_q; // Raw download level delayed

	assign is_bios  = (dl_index == 8'd0);
	assign is_cheat = (dl_index == 8'(`LDR_CHEAT_INDEX));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_download <= 1'b0;
			bios_download <= 1'b0;
			code_download <= 1'b0;
			cart_q        <= 1'b0;
			active_q      <= 1'b0;
			cart_start    <= 1'b0;
			cart_end      <= 1'b0;
			cheat_clear   <= 1'b0;
		end else begin
			// Class levels, one cycle behind the host
			cart_download <= dl_active & ~is_bios & ~is_cheat;
			bios_download <= dl_active & is_bios;
			code_download <= dl_active & is_cheat;

			cart_q     <= cart_download;
			cart_start <= cart_download & ~cart_q;  // Rise of the cart level
			cart_end   <= ~cart_download & cart_q;  // Fall of the cart level

			// Cheat clear looks at the raw level, not the class level
			active_q    <= dl_active;
			cheat_clear <= dl_active & ~active_q & is_cheat;
		end
	end

endmodule

/* loader_pkg.sv */
`include "loader_config.svh"

package loader_pkg;

	// ==================================================
	// Host download stream
	// ==================================================

	typedef struct packed {
		logic                   wr;   // Single cycle write strobe
		logic [`LDR_ADDR_W-1:0] addr; // Byte address, always even
		logic [`LDR_DATA_W-1:0] dout; // Low byte goes to the even address
	} ioctl_word_t;

	// Packed BIOS word
	// Low halfword arrives first
	typedef logic [31:0] bios_data_t;

	typedef struct packed {
		logic [`LDR_BIOS_ADDR_W-1:0] addr; // Word address into BIOS RAM
		bios_data_t                  data;
	} bios_word_t;

	// Cheat record as it streams in, flags word first
	typedef struct packed {
		logic [31:0] replace;
		logic [31:0] compare;
		logic [31:0] address;
		logic [31:0] flags;   // Halfword slots 0 and 1
	} cheat_code_t;

	typedef struct packed {
		logic                   cart_loaded;        // A cartridge has been downloaded
		logic [1:0]             cart_type;          // Index bits 7:6 of the download
		logic                   flash_1m;           // 128 KB flash save type
		logic                   sram_quirk;
		logic                   memory_remap_quirk;
		logic [`LDR_ADDR_W-3:0] max_pak_addr;       // Last word address of the image
	} cart_info_t;

	// ==================================================
	// Scanner constants
	// ==================================================

	localparam logic [`LDR_TAG_BYTES*8-1:0] FLASH_TAG = "FLASH1M_V";

	typedef struct packed {
		logic [`LDR_TITLE_LEN*8-1:0] title; // First character in the top byte
		logic                        sram;  // Disable SRAM/flash save
		logic                        remap; // NES classic memory mirroring
	} quirk_entry_t;

	localparam quirk_entry_t QUIRK_TABLE [`LDR_QUIRK_N] = '{
		'{title: "ROCKY BOXING",           sram: 1'b1, remap: 1'b0},
		'{title: "DBZ LGCYGOKU",           sram: 1'b1, remap: 1'b0},
		// NES classics need both
		'{title: {"BOMBER MAN", 16'h0000}, sram: 1'b1, remap: 1'b1},
		'{title: {"CASTLEVANIA", 8'h00},   sram: 1'b1, remap: 1'b1},
		'{title: {"DONKEY KONG", 8'h00},   sram: 1'b1, remap: 1'b1},
		'{title: {"DR. MARIO", 24'h000000}, sram: 1'b1, remap: 1'b1},
		'{title: {"SUPER MARIO", 8'h00},   sram: 1'b1, remap: 1'b1},
		'{title: {"ZELDA 1", 40'h0000000000}, sram: 1'b1, remap: 1'b1}
	};

endpackage

/* loader_config.svh */
`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// ==================================================
// Download stream geometry
// ==================================================

`define LDR_ADDR_W      27  // Byte address width of the host stream
`define LDR_DATA_W      16  // One halfword per write strobe
`define LDR_BIOS_ADDR_W 12  // BIOS word address, 16 KB image

// Index 0 is the BIOS and every other index that is not the cheat slot is a cartridge
`define LDR_CHEAT_INDEX 255

// ==================================================
// Cartridge header layout
// ==================================================

`define LDR_TITLE_OFS 'hA0  // Game title inside the ROM header
`define LDR_TITLE_LEN 12    // Title bytes, zero padded
`define LDR_QUIRK_N   8     // Entries in the title quirk table
`define LDR_TAG_BYTES 9     // Length of the flash tag string

`endif
